/* logic/mipsPkg.sv */
package mipsPkg;

	// machine word and register index widths
	localparam int dataW = 32;
	localparam int regAddrW = 5;

	// divider iteration count and its counter width
	localparam int divIters = 32;
	localparam int divCntW = $clog2(divIters);

	// E-stage operand source
	typedef enum logic [1:0] {
		fwdNone = 2'b00,
		fwdMem  = 2'b01,
		fwdWb   = 2'b10
	} fwdT;

	// primary opcodes, MIPS encodings
	typedef enum logic [5:0] {
		opRtype = 6'h00,
		opBeq   = 6'h04,
		opAddi  = 6'h08,
		opLw    = 6'h23,
		opSw    = 6'h2b
	} opT;

	// R-type function codes
	// div uses the divu slot, quotient goes to rd
	typedef enum logic [5:0] {
		fnDiv = 6'h1b,
		fnAdd = 6'h20,
		fnSub = 6'h22,
		fnAnd = 6'h24,
		fnOr  = 6'h25,
		fnSlt = 6'h2a
	} functT;

	typedef enum logic [2:0] {aluAdd, aluSub, aluAnd, aluOr, aluSlt} aluOpT;

	typedef enum logic [1:0] {divIdle, divRun, divDone} divStateT;

endpackage

/* logic/hazard.sv */
module hazard (
	// decode stage
	input logic [mipsPkg::regAddrW-1:0] rsD,
	input logic [mipsPkg::regAddrW-1:0] rtD,
	input logic branchD,
	output logic fwdAD,
	output logic fwdBD,
	// execute stage
	input logic [mipsPkg::regAddrW-1:0] rsE,
	input logic [mipsPkg::regAddrW-1:0] rtE,
	input logic [mipsPkg::regAddrW-1:0] writeRegE,
	input logic regWriteE,
	input logic memToRegE,
	input logic divBusyE,
	output mipsPkg::fwdT fwdAE,
	output mipsPkg::fwdT fwdBE,
	// memory and writeback stages
	input logic [mipsPkg::regAddrW-1:0] writeRegM,
	input logic [mipsPkg::regAddrW-1:0] writeRegW,
	input logic regWriteM,
	input logic regWriteW,
	input logic memToRegM,
	// stage controls
	output logic stallF,
	output logic stallD,
	output logic stallE,
	output logic flushE,
	output logic flushM
);
	import mipsPkg::*;

	logic lwStallD;
	logic branchStallD;
	logic holdD;

	// branch compare only sees M, W comes through the regfile bypass
	assign fwdAD = (rsD != '0) && regWriteM && (rsD == writeRegM);
	assign fwdBD = (rtD != '0) && regWriteM && (rtD == writeRegM);

	// ALU operands, newest producer first
	assign fwdAE = (rsE != '0) && regWriteM && (rsE == writeRegM) ? fwdMem :
		(rsE != '0) && regWriteW && (rsE == writeRegW) ? fwdWb : fwdNone;
	assign fwdBE = (rtE != '0) && regWriteM && (rtE == writeRegM) ? fwdMem :
		(rtE != '0) && regWriteW && (rtE == writeRegW) ? fwdWb : fwdNone;

	// load in E feeding the instruction in D
	assign lwStallD = memToRegE && ((rtE == rsD) || (rtE == rtD));

	// beq needs its operands in D
	// an ALU result still in E, or a load still in M, is too late
	assign branchStallD = branchD &&
		((regWriteE && ((writeRegE == rsD) || (writeRegE == rtD))) ||
		(memToRegM && ((writeRegM == rsD) || (writeRegM == rtD))));

	assign holdD = lwStallD || branchStallD;

	// divide freezes F, D and E and drains M
	assign stallF = holdD || divBusyE;
	assign stallD = holdD || divBusyE;
	assign stallE = divBusyE;
	assign flushM = divBusyE;

	// bubble behind a D stall, unless E is frozen anyway
	assign flushE = holdD && !divBusyE;

endmodule

/* logic/regFile.sv */
module regFile (
	input logic clk,
	input logic rst,
	input logic [mipsPkg::regAddrW-1:0] ra1,
	input logic [mipsPkg::regAddrW-1:0] ra2,
	input logic [mipsPkg::regAddrW-1:0] wa,
	input logic we,
	input logic [mipsPkg::dataW-1:0] wd,
	output logic [mipsPkg::dataW-1:0] rd1,
	output logic [mipsPkg::dataW-1:0] rd2
);
	import mipsPkg::*;

	logic [dataW-1:0] regs [1 << regAddrW];

	// r0 never written
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < (1 << regAddrW); i++)
				regs[i] <= '0;
		end else if (we && (wa != '0)) begin
			regs[wa] <= wd;
		end
	end

	// r0 reads zero, a same-cycle write shows through
	function automatic logic [dataW-1:0] readPort(input logic [regAddrW-1:0] ra);
		if (ra == '0)
			return '0;
		if (we && (wa == ra))
			return wd;
		return regs[ra];
	endfunction

	always_comb begin
		rd1 = readPort(ra1);
		rd2 = readPort(ra2);
	end

endmodule

/* logic/decoder.sv */
module decoder (
	input mipsPkg::opT op,
	input mipsPkg::functT funct,
	output logic regWrite,
	output logic memToReg,
	output logic memWrite,
	output logic aluSrcImm,
	output logic regDst,
	output logic branch,
	output logic isDiv,
	output mipsPkg::aluOpT aluOp
);
	import mipsPkg::*;

	always_comb begin
		// bubble unless a known encoding says otherwise
		regWrite = 1'b0;
		memToReg = 1'b0;
		memWrite = 1'b0;
		aluSrcImm = 1'b0;
		regDst = 1'b0;
		branch = 1'b0;
		isDiv = 1'b0;
		aluOp = aluAdd;
		case (op)
			opRtype: begin
				// only listed functions write rd
				regDst = 1'b1;
				regWrite = 1'b1;
				case (funct)
					fnAdd: aluOp = aluAdd;
					fnSub: aluOp = aluSub;
					fnAnd: aluOp = aluAnd;
					fnOr: aluOp = aluOr;
					fnSlt: aluOp = aluSlt;
					fnDiv: isDiv = 1'b1;
					default: begin
						regWrite = 1'b0;
						regDst = 1'b0;
					end
				endcase
			end
			opAddi: begin
				regWrite = 1'b1;
				aluSrcImm = 1'b1;
			end
			opLw: begin
				regWrite = 1'b1;
				memToReg = 1'b1;
				aluSrcImm = 1'b1;
			end
			opSw: begin
				memWrite = 1'b1;
				aluSrcImm = 1'b1;
			end
			// compare happens in D, ALU op unused
			opBeq: begin
				branch = 1'b1;
				aluOp = aluSub;
			end
			default: ;
		endcase
	end

endmodule

/* logic/divCtrl.sv */
module divCtrl (
	input logic clk,
	input logic rst,
	input logic start,
	input logic iterDone,
	output logic load,
	output logic step,
	output logic busy
);
	import mipsPkg::*;

	divStateT state;
	divStateT stateNext;

	always_ff @(posedge clk) begin
		if (rst)
			state <= divIdle;
		else
			state <= stateNext;
	end

	always_comb begin
		stateNext = state;
		load = 1'b0;
		step = 1'b0;
		busy = 1'b0;
		case (state)
			// start cycle already counts as busy
			divIdle: begin
				if (start) begin
					load = 1'b1;
					busy = 1'b1;
					stateNext = divRun;
				end
			end
			// one quotient bit per cycle
			divRun: begin
				step = 1'b1;
				busy = 1'b1;
				if (iterDone)
					stateNext = divDone;
			end
			// quotient valid, busy low so the div leaves E
			divDone: stateNext = divIdle;
			default: stateNext = divIdle;
		endcase
	end

endmodule

/* logic/iterTimer.sv */
module iterTimer (
	input logic clk,
	input logic rst,
	input logic load,
	input logic step,
	output logic iterDone
);
	import mipsPkg::*;

	// steps left minus one
	logic [divCntW-1:0] count;

	always_ff @(posedge clk) begin
		if (rst)
			count <= '0;
		else if (load)
			count <= divCntW'(divIters - 1);
		else if (step)
			count <= count - 1'b1;
	end

	// last step is the one taken at zero
	assign iterDone = step && (count == '0);

endmodule

/* logic/divider.sv */
module divider (
	input logic clk,
	input logic rst,
	input logic start,
	input logic [mipsPkg::dataW-1:0] dividend,
	input logic [mipsPkg::dataW-1:0] divisor,
	output logic [mipsPkg::dataW-1:0] quotient,
	output logic busy
);
	import mipsPkg::*;

	logic load;
	logic step;
	logic iterDone;

	// partial remainder, quotient shifter, latched divisor
	logic [dataW-1:0] remR;
	logic [dataW-1:0] quoR;
	logic [dataW-1:0] dvsR;

	// remainder shifted left with next dividend bit
	logic [dataW:0] trial;
	logic [dataW:0] diff;

	divCtrl divCtrl_inst (
		.clk(clk),
		.rst(rst),
		.start(start),
		.iterDone(iterDone),
		.load(load),
		.step(step),
		.busy(busy)
	);

	iterTimer iterTimer_inst (
		.clk(clk),
		.rst(rst),
		.load(load),
		.step(step),
		.iterDone(iterDone)
	);

	assign trial = {remR, quoR[dataW-1]};
	assign diff = trial - {1'b0, dvsR};

	// restoring step, borrow means keep the shifted remainder
	// zero divisor never borrows, all ones falls out
	always_ff @(posedge clk) begin
		if (load) begin
			remR <= '0;
			quoR <= dividend;
			dvsR <= divisor;
		end else if (step) begin
			remR <= diff[dataW] ? trial[dataW-1:0] : diff[dataW-1:0];
			quoR <= {quoR[dataW-2:0], ~diff[dataW]};
		end
	end

	assign quotient = quoR;

endmodule

/* logic/pipeCore.sv */
module pipeCore (
	input logic clk,
	input logic rst,
	input logic [mipsPkg::dataW-1:0] instrF,
	input logic [mipsPkg::dataW-1:0] readData,
	output logic [mipsPkg::dataW-1:0] pcF,
	output logic [mipsPkg::dataW-1:0] dataAddr,
	output logic [mipsPkg::dataW-1:0] writeData,
	output logic memWrite
);
	import mipsPkg::*;

	// hazard controls
	logic stallF, stallD, stallE, flushE, flushM;
	logic fwdAD, fwdBD;
	fwdT fwdAE, fwdBE;

	// decode stage
	logic [dataW-1:0] instrD, pcPlus4D, immD, rd1D, rd2D, cmpAD, cmpBD, pcBranchD;
	logic [regAddrW-1:0] rsD, rtD, rdD, writeRegD;
	logic regWriteD, memToRegD, memWriteD, aluSrcImmD, regDstD, branchD, isDivD, pcSrcD;
	aluOpT aluOpD;

	// execute stage
	logic [dataW-1:0] rd1E, rd2E, immE, srcAE, srcBE, writeDataE, aluResE, resultE;
	logic [dataW-1:0] quotientE;
	logic [regAddrW-1:0] rsE, rtE, writeRegE;
	logic regWriteE, memToRegE, memWriteE, aluSrcImmE, isDivE, divBusyE;
	aluOpT aluOpE;

	// memory and writeback stages
	logic [dataW-1:0] aluOutM, writeDataM, aluOutW, readDataW, resultW;
	logic [regAddrW-1:0] writeRegM, writeRegW;
	logic regWriteM, memToRegM, memWriteM, regWriteW, memToRegW;

	////////////////////////////////////////
	// fetch
	////////////////////////////////////////

	// taken beq redirects after its delay slot is fetched
	always_ff @(posedge clk) begin
		if (rst)
			pcF <= '0;
		else if (!stallF)
			pcF <= pcSrcD ? pcBranchD : pcF + 4;
	end

	// reset leaves an all-zero word, which decodes to nothing
	always_ff @(posedge clk) begin
		if (rst) begin
			instrD <= '0;
			pcPlus4D <= '0;
		end else if (!stallD) begin
			instrD <= instrF;
			pcPlus4D <= pcF + 4;
		end
	end

	////////////////////////////////////////
	// decode
	////////////////////////////////////////

	assign rsD = instrD[25:21];
	assign rtD = instrD[20:16];
	assign rdD = instrD[15:11];
	assign immD = {{(dataW - 16){instrD[15]}}, instrD[15:0]};
	assign writeRegD = regDstD ? rdD : rtD;

	decoder decoder_inst (
		.op(opT'(instrD[31:26])),
		.funct(functT'(instrD[5:0])),
		.regWrite(regWriteD),
		.memToReg(memToRegD),
		.memWrite(memWriteD),
		.aluSrcImm(aluSrcImmD),
		.regDst(regDstD),
		.branch(branchD),
		.isDiv(isDivD),
		.aluOp(aluOpD)
	);

	regFile regFile_inst (
		.clk(clk),
		.rst(rst),
		.ra1(rsD),
		.ra2(rtD),
		.wa(writeRegW),
		.we(regWriteW),
		.wd(resultW),
		.rd1(rd1D),
		.rd2(rd2D)
	);

	// early branch compare, M forwarded
	assign cmpAD = fwdAD ? aluOutM : rd1D;
	assign cmpBD = fwdBD ? aluOutM : rd2D;
	assign pcSrcD = branchD && (cmpAD == cmpBD);
	assign pcBranchD = pcPlus4D + {immD[dataW-3:0], 2'b00};

	// D/E control, bubbled on flush
	always_ff @(posedge clk) begin
		if (rst) begin
			regWriteE <= 1'b0;
			memToRegE <= 1'b0;
			memWriteE <= 1'b0;
			isDivE <= 1'b0;
			rsE <= '0;
			rtE <= '0;
			writeRegE <= '0;
		end else if (!stallE) begin
			regWriteE <= regWriteD && !flushE;
			memToRegE <= memToRegD && !flushE;
			memWriteE <= memWriteD && !flushE;
			isDivE <= isDivD && !flushE;
			rsE <= rsD;
			rtE <= rtD;
			writeRegE <= writeRegD;
		end
	end

	// D/E payload
	always_ff @(posedge clk) begin
		if (!stallE) begin
			rd1E <= rd1D;
			rd2E <= rd2D;
			immE <= immD;
			aluOpE <= aluOpD;
			aluSrcImmE <= aluSrcImmD;
		end
	end

	////////////////////////////////////////
	// execute
	////////////////////////////////////////

	always_comb begin
		case (fwdAE)
			fwdMem: srcAE = aluOutM;
			fwdWb: srcAE = resultW;
			default: srcAE = rd1E;
		endcase
		case (fwdBE)
			fwdMem: writeDataE = aluOutM;
			fwdWb: writeDataE = resultW;
			default: writeDataE = rd2E;
		endcase
	end

	assign srcBE = aluSrcImmE ? immE : writeDataE;

	always_comb begin
		case (aluOpE)
			aluSub: aluResE = srcAE - srcBE;
			aluAnd: aluResE = srcAE & srcBE;
			aluOr: aluResE = srcAE | srcBE;
			// signed compare
			aluSlt: aluResE = {{(dataW - 1){1'b0}}, $signed(srcAE) < $signed(srcBE)};
			default: aluResE = srcAE + srcBE;
		endcase
	end

	// operands latched on the start cycle, so later forwarding changes are harmless
	divider divider_inst (
		.clk(clk),
		.rst(rst),
		.start(isDivE),
		.dividend(srcAE),
		.divisor(writeDataE),
		.quotient(quotientE),
		.busy(divBusyE)
	);

	assign resultE = isDivE ? quotientE : aluResE;

	// E/M, bubbles while a divide holds E
	always_ff @(posedge clk) begin
		if (rst) begin
			regWriteM <= 1'b0;
			memToRegM <= 1'b0;
			memWriteM <= 1'b0;
			writeRegM <= '0;
		end else begin
			regWriteM <= regWriteE && !flushM;
			memToRegM <= memToRegE && !flushM;
			memWriteM <= memWriteE && !flushM;
			writeRegM <= writeRegE;
		end
	end

	always_ff @(posedge clk) begin
		aluOutM <= resultE;
		writeDataM <= writeDataE;
	end

	////////////////////////////////////////
	// memory and writeback
	////////////////////////////////////////

	assign dataAddr = aluOutM;
	assign writeData = writeDataM;
	assign memWrite = memWriteM;

	always_ff @(posedge clk) begin
		if (rst) begin
			regWriteW <= 1'b0;
			memToRegW <= 1'b0;
			writeRegW <= '0;
		end else begin
			regWriteW <= regWriteM;
			memToRegW <= memToRegM;
			writeRegW <= writeRegM;
		end
	end

	always_ff @(posedge clk) begin
		aluOutW <= aluOutM;
		readDataW <= readData;
	end

	assign resultW = memToRegW ? readDataW : aluOutW;

	hazard hazard_inst (
		.rsD(rsD),
		.rtD(rtD),
		.branchD(branchD),
		.fwdAD(fwdAD),
		.fwdBD(fwdBD),
		.rsE(rsE),
		.rtE(rtE),
		.writeRegE(writeRegE),
		.regWriteE(regWriteE),
		.memToRegE(memToRegE),
		.divBusyE(divBusyE),
		.fwdAE(fwdAE),
		.fwdBE(fwdBE),
		.writeRegM(writeRegM),
		.writeRegW(writeRegW),
		.regWriteM(regWriteM),
		.regWriteW(regWriteW),
		.memToRegM(memToRegM),
		.stallF(stallF),
		.stallD(stallD),
		.stallE(stallE),
		.flushE(flushE),
		.flushM(flushM)
	);

endmodule

/* dv/tbMem.sv */
module tbMem (
	input logic clk,
	// instruction side, answers in the same cycle
	input logic [mipsPkg::dataW-1:0] pcF,
	output logic [mipsPkg::dataW-1:0] instrF,
	// data side
	input logic [mipsPkg::dataW-1:0] dataAddr,
	input logic [mipsPkg::dataW-1:0] writeData,
	input logic memWrite,
	output logic [mipsPkg::dataW-1:0] readData
);
	import mipsPkg::*;

	localparam int memWords = 256;

	logic [dataW-1:0] rom [memWords];
	logic [dataW-1:0] ram [memWords];

	// every store the core commits, in order
	logic [dataW-1:0] logAddr [$];
	logic [dataW-1:0] logData [$];

	// word addressed, 1 KiB each
	assign instrF = rom[pcF[9:2]];
	assign readData = ram[dataAddr[9:2]];

	always @(posedge clk) begin
		if (memWrite === 1'b1) begin
			ram[dataAddr[9:2]] = writeData;
			logAddr.push_back(dataAddr);
			logData.push_back(writeData);
		end
	end

	// rom fill is an unknown opcode, decodes to a bubble
	task automatic clearMem();
		for (int i = 0; i < memWords; i++) begin
			rom[i] = {6'h3f, 26'(i)};
			ram[i] = (32'(i) * 32'h9e3779b1) ^ 32'h5a5a0000;
		end
	endtask

	task automatic writeRom(input int idx, input logic [dataW-1:0] word);
		rom[idx] = word;
	endtask

	task automatic writeRam(input logic [dataW-1:0] addr, input logic [dataW-1:0] word);
		ram[addr[9:2]] = word;
	endtask

	task automatic clearLog();
		logAddr.delete();
		logData.delete();
	endtask

	function automatic int storeCount();
		return logAddr.size();
	endfunction

	function automatic logic [dataW-1:0] storeAddr(input int idx);
		return logAddr[idx];
	endfunction

	function automatic logic [dataW-1:0] storeData(input int idx);
		return logData[idx];
	endfunction

endmodule

/* dv/coreTb.sv */
module coreTb;
	import mipsPkg::*;

	localparam int timeoutCycles = 1000;
	localparam logic [15:0] sentinelAddr = 16'h03fc;

	logic clk;
	logic rst;
	logic [dataW-1:0] instrF;
	logic [dataW-1:0] readData;
	logic [dataW-1:0] pcF;
	logic [dataW-1:0] dataAddr;
	logic [dataW-1:0] writeData;
	logic memWrite;

	// program image, data presets, expected store trace
	logic [dataW-1:0] prog [$];
	logic [dataW-1:0] presetAddr [$];
	logic [dataW-1:0] presetValue [$];
	logic [dataW-1:0] expAddr [$];
	logic [dataW-1:0] expData [$];

	pipeCore pipeCore_inst (
		.clk(clk),
		.rst(rst),
		.instrF(instrF),
		.readData(readData),
		.pcF(pcF),
		.dataAddr(dataAddr),
		.writeData(writeData),
		.memWrite(memWrite)
	);

	tbMem tbMem_inst (
		.clk(clk),
		.pcF(pcF),
		.instrF(instrF),
		.dataAddr(dataAddr),
		.writeData(writeData),
		.memWrite(memWrite),
		.readData(readData)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	////////////////////////////////////////
	// checking
	////////////////////////////////////////

	task automatic stopWithFailure();
		$display("Done: errors found");
		$fatal(1, "simulation stopped");
	endtask

	task automatic checkValue(input string testName, input string what,
		input logic [dataW-1:0] expected, input logic [dataW-1:0] actual);
		if (actual !== expected) begin
			$display("[ERROR] %s %s: expected %h actual %h", testName, what, expected, actual);
			stopWithFailure();
		end
	endtask

	////////////////////////////////////////
	// assembler and reference rules
	////////////////////////////////////////

	function automatic logic [dataW-1:0] encodeR(input functT fn,
		input logic [regAddrW-1:0] rd, input logic [regAddrW-1:0] rs,
		input logic [regAddrW-1:0] rt);
		return {opRtype, rs, rt, rd, 5'd0, fn};
	endfunction

	// also used for beq, rs and rt are the compare operands
	function automatic logic [dataW-1:0] encodeI(input opT op,
		input logic [regAddrW-1:0] rt, input logic [regAddrW-1:0] rs,
		input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic logic [dataW-1:0] signExtend(input logic [15:0] imm);
		return {{16{imm[15]}}, imm};
	endfunction

	// unsigned, zero divisor gives all ones
	function automatic logic [dataW-1:0] expectedQuotient(input logic [dataW-1:0] a,
		input logic [dataW-1:0] b);
		if (b == '0)
			return '1;
		return a / b;
	endfunction

	task automatic clearProgram();
		prog.delete();
		presetAddr.delete();
		presetValue.delete();
		expAddr.delete();
		expData.delete();
	endtask

	task automatic appendInstr(input logic [dataW-1:0] word);
		prog.push_back(word);
	endtask

	// sw rt, addr(r0)
	// traced only when it lies on the executed path
	task automatic appendStore(input logic [regAddrW-1:0] rt, input logic [15:0] addr,
		input logic [dataW-1:0] value, input logic executes);
		prog.push_back(encodeI(opSw, rt, 5'd0, addr));
		if (executes) begin
			expAddr.push_back({16'd0, addr});
			expData.push_back(value);
		end
	endtask

	task automatic presetData(input logic [15:0] addr, input logic [dataW-1:0] value);
		presetAddr.push_back({16'd0, addr});
		presetValue.push_back(value);
	endtask

	function automatic logic sentinelSeen();
		int n;
		n = tbMem_inst.storeCount();
		return (n > 0) && (tbMem_inst.storeAddr(n - 1) == {16'd0, sentinelAddr});
	endfunction

	// load, reset, run until the sentinel store, compare the trace
	task automatic runProgram(input string testName);
		int cycles;
		appendStore(5'd0, sentinelAddr, '0, 1'b1);
		@(posedge clk);
		#1;
		rst = 1'b1;
		tbMem_inst.clearMem();
		for (int i = 0; i < prog.size(); i++)
			tbMem_inst.writeRom(i, prog[i]);
		for (int i = 0; i < presetAddr.size(); i++)
			tbMem_inst.writeRam(presetAddr[i], presetValue[i]);
		tbMem_inst.clearLog();
		repeat (10) @(posedge clk);
		#1;
		// fetch starts at zero, no store pending
		checkValue(testName, "pc after reset", '0, pcF);
		checkValue(testName, "memWrite after reset", '0, 32'(memWrite));
		rst = 1'b0;
		cycles = 0;
		while (!sentinelSeen()) begin
			if (cycles >= timeoutCycles) begin
				$display("%s: no store to the sentinel address after %0d cycles",
					testName, timeoutCycles);
				stopWithFailure();
			end
			@(posedge clk);
			#1;
			cycles++;
		end
		checkValue(testName, "store count", 32'(expAddr.size()),
			32'(tbMem_inst.storeCount()));
		for (int i = 0; i < expAddr.size(); i++) begin
			checkValue(testName, $sformatf("store %0d address", i), expAddr[i],
				tbMem_inst.storeAddr(i));
			checkValue(testName, $sformatf("store %0d data", i), expData[i],
				tbMem_inst.storeData(i));
		end
	endtask

	////////////////////////////////////////
	// directed tests
	////////////////////////////////////////

	// each op consumes the one before it through M, the one before that through W
	task automatic aluChainTest();
		logic [15:0] i1, i2, i3;
		logic [dataW-1:0] r1, r2, r3, r4, r5, r6, r7, r8;
		i1 = 16'($urandom);
		i2 = 16'($urandom);
		i3 = 16'($urandom);
		r1 = signExtend(i1);
		r2 = signExtend(i2);
		r3 = r1 + r2;
		r4 = r1 - r3;
		r5 = r4 & r3;
		r6 = r5 | r1;
		r7 = ($signed(r6) < $signed(r3)) ? 32'd1 : 32'd0;
		r8 = r7 + signExtend(i3);
		clearProgram();
		appendInstr(encodeI(opAddi, 5'd1, 5'd0, i1));
		appendInstr(encodeI(opAddi, 5'd2, 5'd0, i2));
		appendInstr(encodeR(fnAdd, 5'd3, 5'd1, 5'd2));
		appendInstr(encodeR(fnSub, 5'd4, 5'd1, 5'd3));
		appendInstr(encodeR(fnAnd, 5'd5, 5'd4, 5'd3));
		appendInstr(encodeR(fnOr, 5'd6, 5'd5, 5'd1));
		appendInstr(encodeR(fnSlt, 5'd7, 5'd6, 5'd3));
		appendInstr(encodeI(opAddi, 5'd8, 5'd7, i3));
		// store data forwarded from M
		appendStore(5'd8, 16'h0100, r8, 1'b1);
		appendStore(5'd3, 16'h0104, r3, 1'b1);
		appendStore(5'd4, 16'h0108, r4, 1'b1);
		appendStore(5'd5, 16'h010c, r5, 1'b1);
		appendStore(5'd6, 16'h0110, r6, 1'b1);
		appendStore(5'd7, 16'h0114, r7, 1'b1);
		runProgram("aluChain");
	endtask

	task automatic loadUseTest();
		logic [15:0] i1;
		logic [dataW-1:0] w1, w2;
		i1 = 16'($urandom);
		w1 = $urandom;
		w2 = $urandom;
		clearProgram();
		presetData(16'h0040, w1);
		presetData(16'h0044, w2);
		appendInstr(encodeI(opAddi, 5'd1, 5'd0, i1));
		appendInstr(encodeI(opLw, 5'd2, 5'd0, 16'h0040));
		appendInstr(encodeR(fnAdd, 5'd3, 5'd2, 5'd1));
		appendStore(5'd3, 16'h0120, w1 + signExtend(i1), 1'b1);
		appendInstr(encodeI(opLw, 5'd4, 5'd0, 16'h0044));
		appendInstr(encodeR(fnAdd, 5'd5, 5'd4, 5'd4));
		appendStore(5'd5, 16'h0124, w2 + w2, 1'b1);
		// loaded word straight into store data
		appendInstr(encodeI(opLw, 5'd6, 5'd0, 16'h0040));
		appendStore(5'd6, 16'h0128, w1, 1'b1);
		runProgram("loadUse");
	endtask

	// beq offset 2 skips one store after the slot
	task automatic branchTest();
		logic [15:0] v;
		logic [dataW-1:0] sv, sv1, memTaken, memNotTaken;
		v = 16'($urandom);
		sv = signExtend(v);
		sv1 = signExtend(v + 16'd1);
		memTaken = sv;
		memNotTaken = sv ^ 32'h0100_0000;
		clearProgram();
		presetData(16'h0048, memTaken);
		presetData(16'h004c, memNotTaken);
		appendInstr(encodeI(opAddi, 5'd1, 5'd0, v));
		// second operand still in E
		appendInstr(encodeI(opAddi, 5'd2, 5'd0, v));
		appendInstr(encodeI(opBeq, 5'd2, 5'd1, 16'd2));
		appendStore(5'd1, 16'h0200, sv, 1'b1);
		appendStore(5'd1, 16'h0204, sv, sv != sv);
		appendStore(5'd2, 16'h0208, sv, 1'b1);
		appendInstr(encodeI(opAddi, 5'd3, 5'd0, v + 16'd1));
		appendInstr(encodeI(opBeq, 5'd3, 5'd1, 16'd2));
		appendStore(5'd1, 16'h020c, sv, 1'b1);
		appendStore(5'd3, 16'h0210, sv1, sv != sv1);
		appendStore(5'd1, 16'h0214, sv, 1'b1);
		// load sits in M when beq reaches D
		appendInstr(encodeI(opLw, 5'd4, 5'd0, 16'h0048));
		appendInstr(encodeI(opAddi, 5'd9, 5'd0, 16'd1));
		appendInstr(encodeI(opBeq, 5'd1, 5'd4, 16'd2));
		appendStore(5'd4, 16'h0218, memTaken, 1'b1);
		appendStore(5'd4, 16'h021c, memTaken, memTaken != sv);
		appendStore(5'd9, 16'h0220, 32'd1, 1'b1);
		appendInstr(encodeI(opLw, 5'd5, 5'd0, 16'h004c));
		appendInstr(encodeI(opAddi, 5'd9, 5'd0, 16'd2));
		appendInstr(encodeI(opBeq, 5'd1, 5'd5, 16'd2));
		appendStore(5'd5, 16'h0224, memNotTaken, 1'b1);
		appendStore(5'd9, 16'h0228, 32'd2, memNotTaken != sv);
		appendStore(5'd1, 16'h022c, sv, 1'b1);
		runProgram("branch");
	endtask

	task automatic divideTest();
		logic [dataW-1:0] a1, b1, a2, a3, b3, q1, q2, q3;
		a1 = $urandom;
		b1 = $urandom >> 20;
		a2 = $urandom;
		a3 = $urandom;
		b3 = $urandom;
		q1 = expectedQuotient(a1, b1);
		q2 = expectedQuotient(a2, '0);
		q3 = expectedQuotient(a3, b3);
		clearProgram();
		presetData(16'h0050, a1);
		presetData(16'h0054, b1);
		presetData(16'h0058, a2);
		presetData(16'h005c, a3);
		presetData(16'h0060, b3);
		appendInstr(encodeI(opLw, 5'd1, 5'd0, 16'h0050));
		appendInstr(encodeI(opLw, 5'd2, 5'd0, 16'h0054));
		appendInstr(encodeR(fnDiv, 5'd3, 5'd1, 5'd2));
		appendInstr(encodeR(fnAdd, 5'd4, 5'd3, 5'd1));
		appendStore(5'd3, 16'h0300, q1, 1'b1);
		appendStore(5'd4, 16'h0304, q1 + a1, 1'b1);
		// zero divisor from r0
		appendInstr(encodeI(opLw, 5'd5, 5'd0, 16'h0058));
		appendInstr(encodeR(fnDiv, 5'd6, 5'd5, 5'd0));
		appendInstr(encodeR(fnAdd, 5'd7, 5'd6, 5'd5));
		appendStore(5'd6, 16'h0308, q2, 1'b1);
		appendStore(5'd7, 16'h030c, q2 + a2, 1'b1);
		appendInstr(encodeI(opLw, 5'd8, 5'd0, 16'h005c));
		appendInstr(encodeI(opLw, 5'd10, 5'd0, 16'h0060));
		appendInstr(encodeR(fnDiv, 5'd11, 5'd8, 5'd10));
		appendStore(5'd11, 16'h0310, q3, 1'b1);
		runProgram("divide");
	endtask

	// divides, loads and branches interleaved with stores
	task automatic storeOrderTest();
		logic [dataW-1:0] a, b, c, q1, s5, q6, q7, q13;
		logic taken2;
		a = $urandom;
		b = 32'($urandom % 16) + 32'd2;
		c = $urandom;
		q1 = expectedQuotient(a, b);
		s5 = c + q1;
		q6 = expectedQuotient(s5, b);
		q7 = expectedQuotient(q6, b);
		q13 = expectedQuotient(c, b);
		taken2 = (q7 == '0);
		clearProgram();
		presetData(16'h0064, a);
		presetData(16'h0068, b);
		presetData(16'h006c, c);
		appendInstr(encodeI(opLw, 5'd1, 5'd0, 16'h0064));
		appendInstr(encodeI(opLw, 5'd2, 5'd0, 16'h0068));
		appendInstr(encodeR(fnDiv, 5'd3, 5'd1, 5'd2));
		appendStore(5'd3, 16'h0330, q1, 1'b1);
		appendInstr(encodeI(opLw, 5'd4, 5'd0, 16'h006c));
		appendInstr(encodeR(fnAdd, 5'd5, 5'd4, 5'd3));
		// always taken, operand from the add in E
		appendInstr(encodeI(opBeq, 5'd5, 5'd5, 16'd2));
		appendStore(5'd5, 16'h0334, s5, 1'b1);
		appendStore(5'd1, 16'h0338, a, 1'b0);
		// back to back dependent divides
		appendInstr(encodeR(fnDiv, 5'd6, 5'd5, 5'd2));
		appendInstr(encodeR(fnDiv, 5'd7, 5'd6, 5'd2));
		appendStore(5'd6, 16'h033c, q6, 1'b1);
		appendStore(5'd7, 16'h0340, q7, 1'b1);
		appendInstr(encodeI(opBeq, 5'd0, 5'd7, 16'd2));
		appendStore(5'd2, 16'h0344, b, 1'b1);
		appendStore(5'd4, 16'h0348, c, !taken2);
		appendInstr(encodeR(fnDiv, 5'd13, 5'd4, 5'd2));
		appendStore(5'd13, 16'h034c, q13, 1'b1);
		runProgram("storeOrder");
	endtask

	initial begin
		rst = 1'b1;
		void'($urandom(32'hedbc82a3));
		aluChainTest();
		loadUseTest();
		branchTest();
		divideTest();
		storeOrderTest();
		$display("Done: no errors");
		$finish;
	end

endmodule

/* src.f */
logic/mipsPkg.sv
logic/hazard.sv
logic/regFile.sv
logic/decoder.sv
logic/divCtrl.sv
logic/iterTimer.sv
logic/divider.sv
logic/pipeCore.sv
dv/tbMem.sv
dv/coreTb.sv

/* run.sh */
#!/bin/sh
# build with Verilator, run, and decide pass or fail from the log
rm -rf obj_dir sim.log
verilator --binary --timing --top-module coreTb -f src.f -o coreSim \
	|| { echo "build failed"; exit 1; }
./obj_dir/coreSim > sim.log 2>&1
cat sim.log
grep -qx "Done: no errors" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
